//--- sim/meshRouterTb.sv
`timescale 1ns/1ps

module meshRouterTb;
  import nocPkg::*;

  localparam int meshX = 1;
  localparam int meshY = 1;
  localparam int maxPkts = 32;
  localparam int stimCols = 6;

  logic                clk = 1'b0;
  logic                rst;
  linkT                inLinks [numPorts];
  logic [numPorts-1:0] inReady;
  linkT                outLinks [numPorts];
  logic [numPorts-1:0] outReady;

  logic [31:0] stimWords [stimCols * maxPkts];
  int pktSrc [maxPkts];
  int pktX [maxPkts];
  int pktY [maxPkts];
  int pktLen [maxPkts];
  int pktStart [maxPkts];
  int pktRoute [maxPkts];
  int firstFlit [maxPkts];    // offset of the header in its input's flit stream.
  int srcPkts [numPorts][maxPkts];
  int srcCount [numPorts];
  int drvPkt [numPorts];
  int drvIdx [numPorts];
  int acceptedCnt [numPorts];
  int headPkt [numPorts];     // oldest packet of an input whose tail has not left.
  int nextHdr [numPorts];
  int curPkt [numPorts];      // packet in progress on an output, or -1.
  int curIdx [numPorts];
  int rrNext [numPorts];      // input that must own the next header on an output, or -1.
  int numPkts = 0;
  int delivered = 0;
  int cycle = 0;
  int limitCycles = 0;
  int checkCount = 0;
  int valueErrors = 0;
  int otherErrors = 0;
  logic [15:0] lfsr;

  meshRouter #(.routerX(coordW'(meshX)), .routerY(coordW'(meshY)), .fifoDepth(4)) u_meshRouter
  (
    .clk      (clk),
    .rst      (rst),
    .inLinks  (inLinks),
    .inReady  (inReady),
    .outLinks (outLinks),
    .outReady (outReady)
  );

  always #5 clk = ~clk;

  task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp)
    else
    begin
      valueErrors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkCondition(input logic cond, input string msg);
    checkCount++;
    assert (cond)
    else
    begin
      otherErrors++;
      $display("error at %0t: %s", $time, msg);
    end
  endtask

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic int xyPort(input int x, input int y);
    if (x > meshX)
      return int'(portEast);
    if (x < meshX)
      return int'(portWest);
    if (y > meshY)
      return int'(portNorth);
    if (y < meshY)
      return int'(portSouth);
    return int'(portLocal);
  endfunction

  // header carries the packet index as tag, later flits carry tag and flit index.
  function automatic flitT buildFlit(input int g, input int idx);
    flitT   f;
    headerT h;
    if (idx == 0)
    begin
      h.destX = coordW'(pktX[g]);
      h.destY = coordW'(pktY[g]);
      h.length = lengthW'(pktLen[g]);
      h.tag = tagW'(g);
      f.kind = kindHeader;
      f.data = h;
    end
    else
    begin
      f.kind = (idx == pktLen[g] - 1) ? kindTail : kindBody;
      f.data = {tagW'(g), 16'(idx)};
    end
    return f;
  endfunction

  task automatic loadStim();
    int s;
    int flitTotal;
    flitTotal = 0;
    for (int i = 0; i < stimCols * maxPkts; i++)
      stimWords[i] = '1;
    $readmemh("sim/routerStim.txt", stimWords);
    while (numPkts < maxPkts && stimWords[stimCols * numPkts] !== 32'hffff_ffff)
    begin
      s = stimWords[stimCols * numPkts];
      pktSrc[numPkts] = s;
      pktX[numPkts] = stimWords[stimCols * numPkts + 1];
      pktY[numPkts] = stimWords[stimCols * numPkts + 2];
      pktLen[numPkts] = stimWords[stimCols * numPkts + 3];
      pktStart[numPkts] = stimWords[stimCols * numPkts + 4];
      pktRoute[numPkts] = xyPort(pktX[numPkts], pktY[numPkts]);
      checkEqual($sformatf("stim expected port of packet %0d", numPkts),
                 stimWords[stimCols * numPkts + 5], pktRoute[numPkts]);
      checkCondition(s < numPorts && pktLen[numPkts] >= 2,
                     $sformatf("stim packet %0d has a bad source or length", numPkts));
      firstFlit[numPkts] = acceptedCnt[s]; // running flit total, cleared again below.
      acceptedCnt[s] += pktLen[numPkts];
      srcPkts[s][srcCount[s]] = numPkts;
      srcCount[s]++;
      flitTotal += pktLen[numPkts];
      numPkts++;
    end
    checkCondition(numPkts > 0, "stim file holds no packets");
    for (int p = 0; p < numPorts; p++)
      acceptedCnt[p] = 0;
    limitCycles = 20 * flitTotal + 200;
  endtask

  task automatic driveInputs();
    linkT lnk;
    int   g;
    for (int p = 0; p < numPorts; p++)
    begin
      lnk = '0;
      if (drvPkt[p] < srcCount[p])
      begin
        g = srcPkts[p][drvPkt[p]];
        if (drvIdx[p] > 0 || cycle >= pktStart[g])
        begin
          lnk.valid = 1'b1;
          lnk.flit = buildFlit(g, drvIdx[p]);
        end
      end
      inLinks[p] = lnk;
      outReady[p] = lfsrBit();
    end
    cycle++;
  endtask

  task automatic checkIdleState();
    for (int o = 0; o < numPorts; o++)
      checkEqual($sformatf("outLinks[%0d].valid", o), outLinks[o].valid, 1'b0);
    checkEqual("inReady", inReady, {numPorts{1'b1}});
  endtask

  // first input after s whose header for output o sits at its FIFO head.
  function automatic int nextWaiting(input int o, input int s);
    int j;
    int g;
    for (int step = 1; step < numPorts; step++)
    begin
      j = (s + step) % numPorts;
      if (headPkt[j] < srcCount[j])
      begin
        g = srcPkts[j][headPkt[j]];
        if (pktRoute[g] == o && acceptedCnt[j] > firstFlit[g])
          return j;
      end
    end
    return -1;
  endfunction

  task automatic scoreFlit(input int o, input flitT f);
    headerT h;
    int     g;
    int     s;
    h = headerT'(f.data);
    g = int'(h.tag);
    if (curPkt[o] < 0 && (f.kind != kindHeader || g >= numPkts))
      checkCondition(1'b0, $sformatf("output %0d sent flit %h outside any packet", o, f));
    else
    begin
      if (curPkt[o] < 0)
      begin
        s = pktSrc[g];
        checkEqual($sformatf("output port of packet %0d", g), o, pktRoute[g]);
        checkEqual($sformatf("next packet from input %0d", s), g,
                   (nextHdr[s] < srcCount[s]) ? srcPkts[s][nextHdr[s]] : -1);
        if (rrNext[o] >= 0)
          checkEqual($sformatf("input granted on output %0d", o), s, rrNext[o]);
        rrNext[o] = -1;
        nextHdr[s]++;
        curPkt[o] = g;
        curIdx[o] = 0;
      end
      checkEqual($sformatf("outLinks[%0d].flit", o), f, buildFlit(curPkt[o], curIdx[o]));
      curIdx[o]++;
      if (curIdx[o] == pktLen[curPkt[o]])
      begin
        delivered++;
        headPkt[pktSrc[curPkt[o]]]++;
        curPkt[o] = -1;
      end
    end
  endtask

  task automatic noteAccepted(input int p);
    acceptedCnt[p]++;
    drvIdx[p]++;
    if (drvIdx[p] == pktLen[srcPkts[p][drvPkt[p]]])
    begin
      drvPkt[p]++;
      drvIdx[p] = 0;
    end
  endtask

  // sampled before the edge updates any register.
  always @(posedge clk)
  begin
    if (!rst)
    begin
      for (int o = 0; o < numPorts; o++)
        if (outLinks[o].valid && outReady[o] && curPkt[o] >= 0
            && curIdx[o] == pktLen[curPkt[o]] - 1)
          rrNext[o] = nextWaiting(o, pktSrc[curPkt[o]]);
      for (int o = 0; o < numPorts; o++)
        if (outLinks[o].valid && outReady[o])
          scoreFlit(o, outLinks[o].flit);
      for (int p = 0; p < numPorts; p++)
        if (inLinks[p].valid && inReady[p])
          noteAccepted(p);
    end
  end

  initial
  begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d packets delivered",
             limitCycles, delivered, numPkts);
    $display("checks %0d, value errors %0d, other errors %0d", checkCount, valueErrors,
             otherErrors + 1);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    rst = 1'b1;
    outReady = '1;
    lfsr = 16'd39795;
    for (int p = 0; p < numPorts; p++)
    begin
      inLinks[p] = '0;
      srcCount[p] = 0;
      drvPkt[p] = 0;
      drvIdx[p] = 0;
      acceptedCnt[p] = 0;
      headPkt[p] = 0;
      nextHdr[p] = 0;
      curPkt[p] = -1;
      curIdx[p] = 0;
      rrNext[p] = -1;
    end
    loadStim();
    repeat (3)
    begin
      @(negedge clk);
      checkIdleState();
    end
    rst = 1'b0;
    @(negedge clk);
    checkIdleState();
    while (delivered < numPkts)
    begin
      driveInputs();
      @(negedge clk);
    end
    repeat (8)
    begin
      driveInputs();
      @(negedge clk);
    end
    checkIdleState();
    for (int p = 0; p < numPorts; p++)
      checkEqual($sformatf("packets delivered from input %0d", p), nextHdr[p], srcCount[p]);
    $display("checks %0d, value errors %0d, other errors %0d", checkCount, valueErrors,
             otherErrors);
    if (valueErrors + otherErrors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- sim/routerStim.txt
// one packet per line in hex: source destX destY length startCycle expectedPort
// ports are 0 Local, 1 North, 2 East, 3 West, 4 South; the router sits at (1,1)
0 2 1 4 00 2
1 3 0 3 00 2
2 2 2 5 00 2
3 3 3 2 00 2
4 2 0 6 00 2
0 0 1 3 00 3
1 1 0 4 00 4
2 1 1 2 00 0
3 1 3 5 00 1
4 0 2 3 00 3
0 1 1 5 28 0
1 1 1 3 28 0
2 1 1 4 28 0
3 1 1 2 28 0
4 1 1 6 28 0
1 1 2 8 50 1
3 1 3 4 50 1
4 1 2 2 50 1
0 1 0 7 50 4
2 1 0 3 50 4
0 3 2 2 70 2
1 0 0 5 70 3
2 0 3 4 70 3
3 2 3 3 70 2
4 1 3 4 70 1
0 1 2 3 78 1
2 3 1 2 78 2
4 1 1 5 78 0

//--- verilog.f
verilog/nocPkg.sv
verilog/inputFifo.sv
verilog/routeCompute.sv
verilog/packetTimer.sv
verilog/outputArbiter.sv
verilog/meshRouter.sv
sim/meshRouterTb.sv

//--- verilog/inputFifo.sv
`timescale 1ns/1ps

module inputFifo
#(
  parameter int fifoDepth = 4
)
(
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::linkT inLink,
  output logic         inReady,
  output logic         headValid,
  output nocPkg::flitT headFlit,
  input  logic         pop
);
  import nocPkg::*;

  localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
  localparam int cntW = $clog2(fifoDepth + 1);

  flitT            mem [fifoDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic            push;
  logic            doPop;

  assign inReady = (count != cntW'(fifoDepth));
  assign headValid = (count != '0);
  assign headFlit = mem[rdPtr]; // oldest flit is always at the head.
  assign push = inLink.valid && inReady;
  assign doPop = pop && headValid;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inLink.flit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      case ({push, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // push and pop together leave the level alone.
      endcase
    end
  end

endmodule

//--- verilog/meshRouter.sv
`timescale 1ns/1ps

module meshRouter
#(
  parameter logic [nocPkg::coordW-1:0] routerX = '0,
  parameter logic [nocPkg::coordW-1:0] routerY = '0,
  parameter int                        fifoDepth = 4
)
(
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::linkT                inLinks [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] inReady,
  output nocPkg::linkT                outLinks [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0] outReady
);
  import nocPkg::*;

  logic [numPorts-1:0] headValid;
  flitT                headFlits [numPorts];
  logic [numPorts-1:0] pop;
  logic [numPorts-1:0] reqByIn [numPorts];    // bit per output.
  logic [numPorts-1:0] reqByOut [numPorts];   // bit per input.
  logic [numPorts-1:0] grantByOut [numPorts]; // bit per input.
  logic [numPorts-1:0] grantByIn [numPorts];  // bit per output.

  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    inputFifo #(.fifoDepth(fifoDepth)) u_inputFifo
    (
      .clk       (clk),
      .rst       (rst),
      .inLink    (inLinks[i]),
      .inReady   (inReady[i]),
      .headValid (headValid[i]),
      .headFlit  (headFlits[i]),
      .pop       (pop[i])
    );

    routeCompute #(.routerX(routerX), .routerY(routerY)) u_routeCompute
    (
      .clk        (clk),
      .rst        (rst),
      .headValid  (headValid[i]),
      .headFlit   (headFlits[i]),
      .req        (reqByIn[i]),
      .grantReady (grantByIn[i]),
      .pop        (pop[i])
    );

    outputArbiter u_outputArbiter
    (
      .clk        (clk),
      .rst        (rst),
      .req        (reqByOut[i]),
      .headValid  (headValid),
      .headFlits  (headFlits),
      .grantReady (grantByOut[i]),
      .outLink    (outLinks[i]),
      .outReady   (outReady[i])
    );

    for (genvar j = 0; j < numPorts; j++)
    begin : gXpose
      assign reqByOut[i][j] = reqByIn[j][i];
      assign grantByIn[i][j] = grantByOut[j][i];
    end
  end

endmodule

//--- verilog/nocPkg.sv
package nocPkg;

  localparam int numPorts = 5;
  localparam int lengthW = 12;
  localparam int coordW = 2;
  localparam int tagW = 13;
  localparam int dataW = 2 * coordW + lengthW + tagW; // payload bits behind the kind field.

  // router ports in arbitration order.
  typedef enum logic [2:0]
  {
    portLocal,
    portNorth,
    portEast,
    portWest,
    portSouth
  } portE;

  typedef enum logic [2:0]
  {
    kindIdle   = 3'd0,
    kindHeader = 3'd1, // same header code as the older arbiter.
    kindBody   = 3'd2,
    kindTail   = 3'd3
  } flitKindE;

  // header view of the flit payload.
  typedef struct packed
  {
    logic [coordW-1:0]  destX;
    logic [coordW-1:0]  destY;
    logic [lengthW-1:0] length; // flits in the packet including header and tail.
    logic [tagW-1:0]    tag;
  } headerT;

  typedef struct packed
  {
    flitKindE         kind;
    logic [dataW-1:0] data;
  } flitT;

  // ready travels back as its own bit.
  typedef struct packed
  {
    logic valid;
    flitT flit;
  } linkT;

endpackage

//--- verilog/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] req,
  input  logic [nocPkg::numPorts-1:0] headValid,
  input  nocPkg::flitT                headFlits [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] grantReady,
  output nocPkg::linkT                outLink,
  input  logic                        outReady
);
  import nocPkg::*;

  // one-hot states with idle in bit 0 and input i in bit i plus one.
  typedef enum logic [numPorts:0]
  {
    grantIdle  = 6'b000001,
    grantLocal = 6'b000010,
    grantNorth = 6'b000100,
    grantEast  = 6'b001000,
    grantWest  = 6'b010000,
    grantSouth = 6'b100000
  } grantStateE;

  grantStateE          state;
  grantStateE          nextState;
  logic [numPorts-1:0] grantVec;
  logic [numPorts-1:0] moved;
  logic [numPorts-1:0] timerDone;
  portE                grantPort;

  // first requester after the given input, wrapping around.
  function automatic grantStateE pickNext(input logic [numPorts-1:0] reqV, input int last);
    grantStateE        pick;
    logic [numPorts:0] oneHot;
    int                idx;
    pick = grantIdle;
    for (int k = numPorts; k >= 1; k--)
    begin
      idx = (last + k) % numPorts;
      if (reqV[idx])
      begin
        oneHot = '0;
        oneHot[idx + 1] = 1'b1;
        pick = grantStateE'(oneHot);
      end
    end
    return pick;
  endfunction

  assign grantVec = state[numPorts:1];

  always_comb
  begin
    case (state)
      grantNorth: grantPort = portNorth;
      grantEast:  grantPort = portEast;
      grantWest:  grantPort = portWest;
      grantSouth: grantPort = portSouth;
      default:    grantPort = portLocal; // idle and Local both select input 0.
    endcase
  end

  always_comb
  begin
    nextState = state;
    if (state == grantIdle)
      nextState = pickNext(req, numPorts - 1);
    else if (timerDone[grantPort])
      nextState = pickNext(req & ~grantVec, int'(grantPort)); // the finished input waits a turn.
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= grantIdle;
    else
      state <= nextState;
  end

  for (genvar i = 0; i < numPorts; i++)
  begin : gTimer
    packetTimer u_packetTimer
    (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlits[i]),
      .moved    (moved[i]),
      .done     (timerDone[i])
    );
  end

  assign moved = grantVec & headValid & {numPorts{outReady}};
  assign grantReady = grantVec & {numPorts{outReady}};

  assign outLink.valid = |(grantVec & headValid);
  assign outLink.flit = headFlits[grantPort];

endmodule

//--- verilog/packetTimer.sv
`timescale 1ns/1ps

module packetTimer
(
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT headFlit,
  input  logic         moved,
  output logic         done
);
  import nocPkg::*;

  headerT             header;
  logic               isHeader;
  logic [lengthW-1:0] lengthQ;
  logic [lengthW-1:0] curLength;
  logic [lengthW-1:0] count;

  assign header = headerT'(headFlit.data);
  assign isHeader = (headFlit.kind == kindHeader);

  // a header compares against its own length before it is loaded.
  assign curLength = isHeader ? header.length : lengthQ;
  assign done = moved && (count == curLength - 1'b1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lengthQ <= '0;
      count <= '0;
    end
    else
    begin
      if (moved && isHeader)
        lengthQ <= header.length;
      if (done)
        count <= '0;
      else if (moved)
        count <= count + 1'b1; // stalled cycles are not counted.
    end
  end

endmodule

//--- verilog/routeCompute.sv
`timescale 1ns/1ps

module routeCompute
#(
  parameter logic [nocPkg::coordW-1:0] routerX = '0,
  parameter logic [nocPkg::coordW-1:0] routerY = '0
)
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        headValid,
  input  nocPkg::flitT                headFlit,
  output logic [nocPkg::numPorts-1:0] req,
  input  logic [nocPkg::numPorts-1:0] grantReady,
  output logic                        pop
);
  import nocPkg::*;

  headerT header;
  portE   xyRoute;
  portE   routeQ;
  portE   route;
  logic   routeActive;

  assign header = headerT'(headFlit.data);

  // x first, then y.
  always_comb
  begin
    if (header.destX > routerX)
      xyRoute = portEast;
    else if (header.destX < routerX)
      xyRoute = portWest;
    else if (header.destY > routerY)
      xyRoute = portNorth;
    else if (header.destY < routerY)
      xyRoute = portSouth;
    else
      xyRoute = portLocal;
  end

  assign route = routeActive ? routeQ : xyRoute; // only a header is at the head when idle.

  always_comb
  begin
    req = '0;
    if (headValid)
      req[route] = 1'b1;
  end

  assign pop = headValid && grantReady[route];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      routeActive <= 1'b0;
      routeQ <= portLocal;
    end
    else if (pop)
    begin
      if (headFlit.kind == kindHeader)
      begin
        routeActive <= 1'b1;
        routeQ <= xyRoute;
      end
      else if (headFlit.kind == kindTail)
        routeActive <= 1'b0; // the next flit starts a new packet.
    end
  end

endmodule
